// ==== pre_dfe.f ====
+incdir+design
design/pre_dfe_pkg.sv
design/sample_capture.sv
design/rate_sequencer.sv
design/beat_formatter.sv
design/pre_dfe_top.sv
tb/pre_dfe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=pre_dfe_sim

verilator --binary --timing --assert \
  -f pre_dfe.f \
  --top-module pre_dfe_tb \
  --Mdir "${BUILD_DIR}" \
  -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$("./${BUILD_DIR}/${SIM_BIN}")
sim_status=$?
printf '%s\n' "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
  exit 1
fi

if printf '%s\n' "${sim_out}" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/pre_dfe_tb.sv ====
`timescale 1ns/1ps

module pre_dfe_tb;

  import pre_dfe_pkg::*;

  localparam int NUM_BURSTS   = 6;
  localparam int RISE_TIMEOUT = 400;   // fast cycles
  localparam int FALL_TIMEOUT = 64;    // fast cycles
  localparam int MAX_UNREAD   = 3;     // tail samples that may stay in the buffer

  logic       i_clk_491;
  logic       i_clk_122;
  logic       i_rst;
  iq_sample_t i_tdata;
  logic       i_tvalid;
  logic       i_zero_stuff;
  iq_sample_t o_tdata;
  logic [1:0] o_tuser;
  logic       o_tvalid;

  iq_sample_t ref_q[$];       // inputs of the current burst in arrival order
  iq_sample_t cur_sample;     // sample of the group now on the output
  iq_sample_t exp_data;
  logic [1:0] exp_phase;
  logic [1:0] prev_tuser;
  logic       prev_valid;
  int         groups_out;     // phase 0 beats seen in this burst
  int         mismatch_cnt;
  int         fail_cnt;
  int         timeout_cnt;
  logic       idle_watch;     // output must stay quiet
  logic       timed_out;

  pre_dfe_top UUT (
    .i_clk_122    (i_clk_122),
    .i_clk_491    (i_clk_491),
    .i_rst        (i_rst),
    .i_tdata      (i_tdata),
    .i_tvalid     (i_tvalid),
    .i_zero_stuff (i_zero_stuff),
    .o_tdata      (o_tdata),
    .o_tuser      (o_tuser),
    .o_tvalid     (o_tvalid)
  );

  initial begin
    i_clk_491 = 1'b0;
    forever #2 i_clk_491 = ~i_clk_491;
  end

  // slow clock rises together with every fourth fast edge
  initial begin
    i_clk_122 = 1'b0;
    #2 i_clk_122 = 1'b1;
    forever #8 i_clk_122 = ~i_clk_122;
  end

  // per-beat reference check on the values before the edge
  always @(posedge i_clk_491) begin
    if (!i_rst && o_tvalid === 1'b1) begin
      if (prev_valid) begin
        exp_phase = prev_tuser + 2'd1;   // 3 wraps to 0
        phase_steps: assert (o_tuser == exp_phase)
          else begin
            mismatch_cnt++;
            $display("mismatch t=%0t o_tuser expected %0d actual %0d",
                     $time, exp_phase, o_tuser);
          end
      end
      if (o_tuser == 2'd0) begin
        if (ref_q.size() == 0) begin
          fail_cnt++;
          $display("output beat at %0t has no input sample left to match", $time);
        end else begin
          cur_sample = ref_q.pop_front();
          groups_out++;
        end
      end
      if (i_zero_stuff && o_tuser != 2'd0) begin
        exp_data = '0;
      end else begin
        exp_data = cur_sample;
      end
      data_matches: assert (o_tdata == exp_data)
        else begin
          mismatch_cnt++;
          $display("mismatch t=%0t o_tdata expected %h actual %h",
                   $time, exp_data, o_tdata);
        end
    end
    prev_valid = !i_rst && (o_tvalid === 1'b1);
    prev_tuser = o_tuser;
  end

  quiet_before_input: assert property (@(posedge i_clk_491) disable iff (i_rst)
    idle_watch |-> !o_tvalid)
    else begin
      fail_cnt++;
      $display("o_tvalid went high at %0t before any input sample", $time);
    end

  // every burst opens on phase 0
  first_beat_phase: assert property (@(posedge i_clk_491) disable iff (i_rst)
    $rose(o_tvalid) |-> (o_tuser == 2'd0))
    else begin
      mismatch_cnt++;
      $display("mismatch t=%0t o_tuser expected 0 actual %0d", $time, $sampled(o_tuser));
    end

  // one sample per slow cycle until valid drops
  task automatic send_burst(input int len);
    iq_sample_t s;
    int         k;
    for (k = 0; k < len; k++) begin
      s = iq_sample_t'($urandom);
      i_tdata  = s;
      i_tvalid = 1'b1;
      ref_q.push_back(s);
      @(posedge i_clk_122);
      #1;
    end
    i_tvalid = 1'b0;
    i_tdata  = '0;
  endtask

  task automatic wait_tvalid(input logic level, input int limit, output logic ok);
    int cycles;
    cycles = 0;
    while (o_tvalid !== level && cycles < limit) begin
      @(posedge i_clk_491);
      #1;
      cycles++;
    end
    ok = (o_tvalid === level);
    if (!ok) begin
      timeout_cnt++;
      $display("timeout at %0t: o_tvalid did not reach %0b within %0d fast cycles",
               $time, level, limit);
    end
  endtask

  task automatic check_burst_count(input int len);
    if (groups_out < len - MAX_UNREAD) begin
      fail_cnt++;
      $display("burst of %0d samples produced only %0d output groups", len, groups_out);
    end
  endtask

  initial begin
    int   b;
    int   len;
    int   gap;
    logic ok;
    i_rst        = 1'b1;
    i_tdata      = '0;
    i_tvalid     = 1'b0;
    i_zero_stuff = 1'b0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    timeout_cnt  = 0;
    groups_out   = 0;
    cur_sample   = '0;
    idle_watch   = 1'b0;
    timed_out    = 1'b0;
    prev_valid   = 1'b0;
    void'($urandom(32'hc7ab));

    repeat (5) @(posedge i_clk_491);
    #1 i_rst = 1'b0;

    // slow-domain reset clears two slow edges after release
    repeat (4) @(posedge i_clk_122);
    #1 idle_watch = 1'b1;
    repeat (10) @(posedge i_clk_122);
    #1 idle_watch = 1'b0;

    for (b = 0; b < NUM_BURSTS && !timed_out; b++) begin
      i_zero_stuff = (b % 2 == 1);   // odd bursts in zero-stuff mode
      len = 20 + int'($urandom % 21);
      ref_q.delete();
      groups_out = 0;
      send_burst(len);
      wait_tvalid(1'b1, RISE_TIMEOUT, ok);
      if (ok) begin
        wait_tvalid(1'b0, FALL_TIMEOUT, ok);
      end
      if (!ok) begin
        timed_out = 1'b1;
      end else begin
        check_burst_count(len);
        gap = 1 + int'($urandom % 5);
        repeat (gap) @(posedge i_clk_122);
        #1;
      end
    end

    repeat (4) @(posedge i_clk_491);
    $display("errors: %0d value mismatches, %0d other failures, %0d timeouts",
             mismatch_cnt, fail_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== design/pre_dfe_top.sv ====
`timescale 1ns/1ps

module pre_dfe_top (
  input  logic                   i_clk_122,
  input  logic                   i_clk_491,
  input  logic                   i_rst,
  input  pre_dfe_pkg::iq_sample_t i_tdata,
  input  logic                   i_tvalid,
  input  logic                   i_zero_stuff,
  output pre_dfe_pkg::iq_sample_t o_tdata,
  output logic [1:0]             o_tuser,
  output logic                   o_tvalid
);

  import pre_dfe_pkg::*;

  buf_wr_t   wr;     // slow-domain buffer write
  logic      run;    // slow-domain run level
  out_beat_t beat;   // fast-domain beat

  sample_capture u_capture (
    .i_clk_122 (i_clk_122),
    .i_rst     (i_rst),
    .i_tdata   (i_tdata),
    .i_tvalid  (i_tvalid),
    .o_wr      (wr),
    .o_run     (run)
  );

  rate_sequencer u_sequencer (
    .i_clk_122 (i_clk_122),
    .i_clk_491 (i_clk_491),
    .i_rst     (i_rst),
    .i_wr      (wr),
    .i_run     (run),
    .o_beat    (beat)
  );

  beat_formatter u_formatter (
    .i_clk_491    (i_clk_491),
    .i_rst        (i_rst),
    .i_beat       (beat),
    .i_zero_stuff (i_zero_stuff),
    .o_tdata      (o_tdata),
    .o_tuser      (o_tuser),
    .o_tvalid     (o_tvalid)
  );

endmodule

// ==== design/beat_formatter.sv ====
`timescale 1ns/1ps

module beat_formatter (
  input  logic                   i_clk_491,
  input  logic                   i_rst,
  input  pre_dfe_pkg::out_beat_t  i_beat,
  input  logic                   i_zero_stuff,
  output pre_dfe_pkg::iq_sample_t o_tdata,
  output logic [1:0]             o_tuser,
  output logic                   o_tvalid
);

  import pre_dfe_pkg::*;

  iq_sample_t beat_data;   // sample after mode select

  // zero-stuff keeps only phase 0
  always_comb begin
    beat_data = i_beat.sample;
    if (i_zero_stuff && (i_beat.phase != 2'd0)) begin
      beat_data = '0;
    end
  end

  always_ff @(posedge i_clk_491) begin
    o_tdata <= beat_data;
    o_tuser <= i_beat.phase;
  end

  always_ff @(posedge i_clk_491) begin
    if (i_rst) begin
      o_tvalid <= 1'b0;
    end else begin
      o_tvalid <= i_beat.valid;
    end
  end

  // zero-stuff output carries nothing past phase 0
  stuff_zero_phases: assert property (@(posedge i_clk_491) disable iff (i_rst)
    (o_tvalid && i_zero_stuff && (o_tuser != 2'd0)) |-> (o_tdata == '0))
    else $error("nonzero data on phase %0d in zero-stuff mode", o_tuser);

  // hold mode repeats one sample across the group
  hold_repeats_sample: assert property (@(posedge i_clk_491) disable iff (i_rst)
    (o_tvalid && !i_zero_stuff && (o_tuser != 2'd0)) |-> $stable(o_tdata))
    else $error("hold mode sample changed inside a phase group");

endmodule

// ==== design/rate_sequencer.sv ====
`timescale 1ns/1ps
`include "pre_dfe_defines.svh"

module rate_sequencer (
  input  logic                  i_clk_122,
  input  logic                  i_clk_491,
  input  logic                  i_rst,
  input  pre_dfe_pkg::buf_wr_t   i_wr,
  input  logic                  i_run,
  output pre_dfe_pkg::out_beat_t o_beat
);

  import pre_dfe_pkg::*;

  localparam int         DEPTH      = 1 << `PRE_DFE_ADDR_W;
  localparam logic [1:0] LAST_PHASE = 2'(`PRE_DFE_PHASES - 1);

  iq_sample_t                 mem [DEPTH];   // sample buffer
  logic                       run_meta;
  logic                       run_sync;
  logic [1:0]                 phase;
  logic [`PRE_DFE_ADDR_W-1:0] raddr;
  iq_sample_t                 rd_data;
  logic [1:0]                 phase_q;       // aligned with rd_data
  logic                       valid_q;

  // write side on the slow clock
  always_ff @(posedge i_clk_122) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // run level into the fast domain
  always_ff @(posedge i_clk_491) begin
    if (i_rst) begin
      run_meta <= 1'b0;
      run_sync <= 1'b0;
    end else begin
      run_meta <= i_run;
      run_sync <= run_meta;
    end
  end

  // four fast beats per stored sample
  always_ff @(posedge i_clk_491) begin
    if (i_rst || !run_sync) begin
      phase <= '0;
    end else if (phase == LAST_PHASE) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  always_ff @(posedge i_clk_491) begin
    if (i_rst || !run_sync) begin
      raddr <= '0;
    end else if (phase == LAST_PHASE) begin
      raddr <= raddr + 1'b1;   // next sample after the last phase
    end
  end

  // registered read with one cycle of latency
  always_ff @(posedge i_clk_491) begin
    rd_data <= mem[raddr];
    phase_q <= phase;
  end

  always_ff @(posedge i_clk_491) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= run_sync;
    end
  end

  assign o_beat.valid  = valid_q;
  assign o_beat.phase  = phase_q;
  assign o_beat.sample = rd_data;

  // a continuing stream goes 3 then 0
  beat_phase_wraps: assert property (@(posedge i_clk_491) disable iff (i_rst)
    ((valid_q && phase_q == LAST_PHASE) ##1 valid_q) |-> phase_q == 2'd0)
    else $error("beat phase did not wrap to 0 after phase 3");

  // each run starts at phase 0 of slot 0
  run_starts_clear: assert property (@(posedge i_clk_491) disable iff (i_rst)
    $rose(valid_q) |-> (phase_q == 2'd0 && raddr == '0))
    else $error("phase or read address moved without run");

endmodule

// ==== design/sample_capture.sv ====
`timescale 1ns/1ps
`include "pre_dfe_defines.svh"

module sample_capture (
  input  logic                   i_clk_122,
  input  logic                   i_rst,
  input  pre_dfe_pkg::iq_sample_t i_tdata,
  input  logic                   i_tvalid,
  output pre_dfe_pkg::buf_wr_t    o_wr,
  output logic                   o_run
);

  import pre_dfe_pkg::*;

  // run rises when this fill slot is written
  localparam logic [`PRE_DFE_ADDR_W-1:0] LAST_FILL_ADDR = `PRE_DFE_ADDR_W'(`PRE_DFE_FILL - 1);

  logic                       rst_meta;    // reset crossing first stage
  logic                       rst_sync;    // reset in slow domain
  iq_sample_t                 in_data_q;
  logic                       in_valid_q;
  logic [`PRE_DFE_ADDR_W-1:0] waddr;
  logic                       run_q;

  // i_rst comes from the 491 domain
  always_ff @(posedge i_clk_122) begin
    rst_meta <= i_rst;
    rst_sync <= rst_meta;
  end

  always_ff @(posedge i_clk_122) begin
    in_data_q <= i_tdata;   // payload
  end

  always_ff @(posedge i_clk_122) begin
    if (rst_sync) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= i_tvalid;
    end
  end

  // write address walks the burst and clears once valid drops
  always_ff @(posedge i_clk_122) begin
    if (rst_sync) begin
      waddr <= '0;
    end else if (in_valid_q) begin
      waddr <= waddr + 1'b1;   // wraps at 16 while the reader keeps pace
    end else begin
      waddr <= '0;
    end
  end

  // run level for the fast side
  always_ff @(posedge i_clk_122) begin
    if (rst_sync) begin
      run_q <= 1'b0;
    end else if (!in_valid_q) begin
      run_q <= 1'b0;            // end of burst
    end else if (waddr == LAST_FILL_ADDR) begin
      run_q <= 1'b1;            // fill reached
    end
  end

  assign o_wr.en   = in_valid_q;
  assign o_wr.addr = waddr;
  assign o_wr.data = in_data_q;
  assign o_run     = run_q;

  // buffer may only wrap once reads are under way
  wrap_after_fill: assert property (@(posedge i_clk_122) disable iff (rst_sync)
    (in_valid_q && (&waddr)) |-> run_q)
    else $error("write address wrapped before the run level rose");

  // run needs writes in both of the two slow cycles before it
  run_after_writes: assert property (@(posedge i_clk_122) disable iff (rst_sync)
    run_q |-> ($past(in_valid_q) && $past(in_valid_q, 2)))
    else $error("run level high without valid input");

endmodule

// ==== design/pre_dfe_pkg.sv ====
`include "pre_dfe_defines.svh"

package pre_dfe_pkg;

  // one complex baseband sample
  typedef struct packed {
    logic signed [15:0] i;   // upper half
    logic signed [15:0] q;   // lower half
  } iq_sample_t;

  // write port of the dual-clock sample buffer, slow domain
  typedef struct packed {
    logic                       en;     // write strobe
    logic [`PRE_DFE_ADDR_W-1:0] addr;   // buffer slot
    iq_sample_t                 data;
  } buf_wr_t;

  // one fast-domain beat before formatting
  typedef struct packed {
    logic       valid;
    logic [1:0] phase;    // 0 to 3 within the sample
    iq_sample_t sample;
  } out_beat_t;

endpackage

// ==== design/pre_dfe_defines.svh ====
`ifndef PRE_DFE_DEFINES_SVH
`define PRE_DFE_DEFINES_SVH

// sample buffer geometry
`define PRE_DFE_ADDR_W 4   // 16 entries

// samples stored before the read side is released
`define PRE_DFE_FILL 2

// fast beats per slow sample, 491.52 over 122.88
`define PRE_DFE_PHASES 4

`endif
